// File: source/rdmx_defines.svh
/* Widths, FIFO depths and fixed RDMX header field values
   The header fills one beat so RDMX_DATA_W and RDMX_KEEP_W must stay 512 and 64 */
`ifndef RDMX_DEFINES_SVH
`define RDMX_DEFINES_SVH

// ==============================
// Bus widths
// ==============================
`define RDMX_DATA_W       512
`define RDMX_KEEP_W       64
`define RDMX_ADDR_W       64
`define RDMX_USER_W       40
`define RDMX_LEN_W        16

// Input buffering in entries
`define RDMX_DATA_DEPTH   32
`define RDMX_META_DEPTH   8

// Header lengths in bytes
`define RDMX_IP_HDR_LEN   20
`define RDMX_UDP_HDR_LEN  8
`define RDMX_HDR_LEN      22

// ==============================
// Fixed header field values
// ==============================
`define RDMX_SRC_MAC      48'hC400_AD00_0002
`define RDMX_SRC_IP       32'h0A01_0102
`define RDMX_DST_IP       32'h0A01_01FF
`define RDMX_SRC_PORT     16'd1000
`define RDMX_DST_PORT     16'd32002
`define RDMX_MAGIC        16'h0122
`define RDMX_IP_ID        16'hDEAD
`define RDMX_IP_FLAGS     16'h4000
`define RDMX_IP_VER_DSF   16'h4500
`define RDMX_IP_TTL_PROT  16'h4011

`endif

// File: source/rdmx_header_gen.sv
/* Combinational 64-byte Ethernet/IPv4/UDP/RDMX header, byte 0 in the low lane
   IPv4 checksum folds the carry once and the UDP checksum is sent as zero */
`timescale 1ns/1ps
`default_nettype none

`include "rdmx_defines.svh"

module rdmx_header_gen
   import rdmx_pkg::*;
(
   input  wire pkt_len_t     payload_len,
   input  wire target_addr_t target_addr,
   input  wire user_field_t  user_field,
   input  wire seq_num_t     seq_num,
   output data_beat_t        header_beat
);

   localparam int NBYTES = `RDMX_DATA_W / 8;

   // Broadcast destination and IPv4 frame type
   localparam logic [47:0] ETH_DST_MAC  = 48'hFFFF_FFFF_FFFF;
   localparam logic [15:0] ETH_TYPE     = 16'h0800;
   localparam logic [31:0] SRC_IP       = `RDMX_SRC_IP;
   localparam logic [31:0] DST_IP       = `RDMX_DST_IP;
   localparam logic [39:0] RESERVED     = '0;

   // Bytes ahead of the payload inside the IP and UDP datagrams
   localparam pkt_len_t IP_OVERHEAD  =
      pkt_len_t'(`RDMX_IP_HDR_LEN + `RDMX_UDP_HDR_LEN + `RDMX_HDR_LEN);
   localparam pkt_len_t UDP_OVERHEAD = pkt_len_t'(`RDMX_UDP_HDR_LEN + `RDMX_HDR_LEN);

   pkt_len_t    ip_len;
   pkt_len_t    udp_len;
   logic [31:0] cs_sum;
   logic [15:0] cs_fold;
   logic [15:0] ip_csum;
   data_beat_t  hdr_be;

   assign ip_len  = payload_len + IP_OVERHEAD;
   assign udp_len = payload_len + UDP_OVERHEAD;

   // ==============================
   // IPv4 header checksum
   // ==============================
   // Nine half-words, checksum field itself counted as zero
   assign cs_sum = `RDMX_IP_VER_DSF
                 + ip_len
                 + `RDMX_IP_ID
                 + `RDMX_IP_FLAGS
                 + `RDMX_IP_TTL_PROT
                 + SRC_IP[31:16]
                 + SRC_IP[15:0]
                 + DST_IP[31:16]
                 + DST_IP[15:0];

   // One fold is enough for nine 16-bit terms in practice
   assign cs_fold = cs_sum[15:0] + cs_sum[31:16];
   assign ip_csum = ~cs_fold;

   // ==============================
   // Field layout, wire order
   // ==============================
   // First byte on the wire sits in the top lane here
   assign hdr_be = {
      // Ethernet header of 14 bytes
      ETH_DST_MAC, `RDMX_SRC_MAC, ETH_TYPE,
      // IPv4 header of 20 bytes
      `RDMX_IP_VER_DSF, ip_len, `RDMX_IP_ID, `RDMX_IP_FLAGS,
      `RDMX_IP_TTL_PROT, ip_csum, SRC_IP, DST_IP,
      // UDP header of 8 bytes
      `RDMX_SRC_PORT, `RDMX_DST_PORT, udp_len, 16'h0000,
      // RDMX header of 22 bytes
      `RDMX_MAGIC, target_addr, seq_num,
      user_field[31:0], user_field[39:32], RESERVED
   };

   // MAC sends the low byte first, so swap lanes end for end
   always_comb begin
      for (int i = 0; i < NBYTES; i++) begin
         header_beat[i*8 +: 8] = hdr_be[(NBYTES-1-i)*8 +: 8];
      end
   end

endmodule

`default_nettype wire

// File: source/rdmx_pkg.sv
/* Shared types of the RDMX transmit back end */
`default_nettype none

`include "rdmx_defines.svh"

package rdmx_pkg;

   // ==============================
   // Sequencer states
   // ==============================
   typedef enum logic [1:0] {
      TX_IDLE,
      TX_HEADER,
      TX_PAYLOAD
   } tx_state_t;

   // One full beat on the data path
   typedef logic [`RDMX_DATA_W-1:0] data_beat_t;

   // Byte enables of one beat
   typedef logic [`RDMX_KEEP_W-1:0] keep_t;

   // Payload length in bytes
   typedef logic [`RDMX_LEN_W-1:0]  pkt_len_t;

   // Remote target address
   typedef logic [`RDMX_ADDR_W-1:0] target_addr_t;

   // Flags in the top byte, user field below
   typedef logic [`RDMX_USER_W-1:0] user_field_t;

   // Packet sequence number
   typedef logic [15:0]             seq_num_t;

endpackage

`default_nettype wire

// File: source/rdmx_tx_sequencer.sv
/* Sends one header beat and then the packet's data beats with tx_last from the data FIFO
   Assumes length and address heads stay stable until popped */
`timescale 1ns/1ps
`default_nettype none

`include "rdmx_defines.svh"

module rdmx_tx_sequencer
   import rdmx_pkg::*;
(
   input  wire             dst_clk,
   input  wire             dst_resetn,
   input  wire             len_valid,
   input  wire             addr_valid,
   output logic            meta_pop,
   input  wire pkt_len_t   len_head,
   input  wire data_beat_t header_beat,
   input  wire data_beat_t data_head,
   input  wire             data_last,
   input  wire             data_valid,
   output logic            data_pop,
   output seq_num_t        seq_num,
   output data_beat_t      tx_data,
   output keep_t           tx_keep,
   output logic            tx_last,
   output logic            tx_valid,
   input  wire             tx_ready
);

   // Low length bits give the byte count of a partial last beat
   localparam int REM_W = $clog2(`RDMX_KEEP_W);

   tx_state_t         state;
   pkt_len_t          len_latch;
   logic [REM_W-1:0]  rem_bytes;
   logic              meta_ok;

   // Header waits for both metadata entries
   assign meta_ok   = len_valid & addr_valid;
   assign meta_pop  = (state == TX_HEADER) & meta_ok & tx_ready;
   assign data_pop  = (state == TX_PAYLOAD) & data_valid & tx_ready;
   assign rem_bytes = len_latch[REM_W-1:0];

   // ==============================
   // Output mux
   // ==============================
   always_comb begin
      tx_data  = '0;
      tx_valid = 1'b0;
      tx_last  = 1'b0;
      tx_keep  = '1;
      case (state)
         TX_HEADER: begin
            tx_data  = header_beat;
            tx_valid = meta_ok;
         end
         TX_PAYLOAD: begin
            tx_data  = data_head;
            tx_valid = data_valid;
            tx_last  = data_last;
            // Remainder zero means the last beat is full
            if (data_last && rem_bytes != '0) begin
               tx_keep = (keep_t'(1) << rem_bytes) - keep_t'(1);
            end
         end
         default: ;
      endcase
   end

   // ==============================
   // State and sequence counter
   // ==============================
   always_ff @(posedge dst_clk) begin
      if (!dst_resetn) begin
         state   <= TX_IDLE;
         seq_num <= '0;
      end else begin
         case (state)
            TX_IDLE: begin
               seq_num <= seq_num_t'(1);
               state   <= TX_HEADER;
            end
            TX_HEADER: begin
               if (meta_pop) begin
                  seq_num <= seq_num + 1'b1;
                  state   <= TX_PAYLOAD;
               end
            end
            TX_PAYLOAD: begin
               if (data_pop && data_last) begin
                  state <= TX_HEADER;
               end
            end
            default: state <= TX_IDLE;
         endcase
      end
   end

   // Length of the frame in flight for the last keep
   always_ff @(posedge dst_clk) begin
      if (meta_pop) begin
         len_latch <= len_head;
      end
   end

   // A ready header has its packet's first data beat buffered behind it
   assert property (@(posedge dst_clk) disable iff (!dst_resetn)
      state == TX_HEADER && tx_valid |-> data_valid);

   // Stalled beat holds with FIFO heads and header inputs
   assert property (@(posedge dst_clk) disable iff (!dst_resetn)
      tx_valid && !tx_ready |=> tx_valid && $stable(tx_data) && $stable(tx_last));

endmodule

`default_nettype wire

// File: source/rdmx_xmit.sv
/* RDMX transmit back end, single clock domain
   Write a packet's length only after its last beat, its address no later than the length */
`timescale 1ns/1ps
`default_nettype none

`include "rdmx_defines.svh"

module rdmx_xmit
   import rdmx_pkg::*;
(
   input  wire               dst_clk,
   input  wire               dst_resetn,
   // Payload length stream
   input  wire pkt_len_t     plen_data,
   input  wire               plen_valid,
   output wire               plen_ready,
   // Target address stream
   input  wire target_addr_t addr_data,
   input  wire user_field_t  addr_user,
   input  wire               addr_valid,
   output wire               addr_ready,
   // Payload data stream
   input  wire data_beat_t   pkt_data,
   input  wire               pkt_last,
   input  wire               pkt_valid,
   output wire               pkt_ready,
   // Frame output
   output wire data_beat_t   tx_data,
   output wire keep_t        tx_keep,
   output wire               tx_last,
   output wire               tx_valid,
   input  wire               tx_ready,
   output wire               data_fifo_full
);

   // ==============================
   // FIFO heads and pops
   // ==============================
   wire data_beat_t   data_head;
   wire               data_last;
   wire               data_valid;
   wire               data_pop;
   wire pkt_len_t     len_head;
   wire               len_valid;
   wire target_addr_t addr_head;
   wire user_field_t  user_head;
   wire               addr_head_valid;
   wire               meta_pop;
   wire seq_num_t     seq_num;
   wire data_beat_t   header_beat;

   // Last flag rides above the data bits
   stream_fifo #(.WIDTH(`RDMX_DATA_W + 1), .DEPTH(`RDMX_DATA_DEPTH)) data_fifo (
      .dst_clk, .dst_resetn,
      .in_data({pkt_last, pkt_data}), .in_valid(pkt_valid), .in_ready(pkt_ready),
      .out_data({data_last, data_head}), .out_valid(data_valid), .out_ready(data_pop),
      .in_stalled(data_fifo_full));

   stream_fifo #(.WIDTH(`RDMX_LEN_W), .DEPTH(`RDMX_META_DEPTH)) len_fifo (
      .dst_clk, .dst_resetn,
      .in_data(plen_data), .in_valid(plen_valid), .in_ready(plen_ready),
      .out_data(len_head), .out_valid(len_valid), .out_ready(meta_pop),
      .in_stalled());

   // User field and flags above the address
   stream_fifo #(.WIDTH(`RDMX_ADDR_W + `RDMX_USER_W), .DEPTH(`RDMX_META_DEPTH)) addr_fifo (
      .dst_clk, .dst_resetn,
      .in_data({addr_user, addr_data}), .in_valid(addr_valid), .in_ready(addr_ready),
      .out_data({user_head, addr_head}), .out_valid(addr_head_valid), .out_ready(meta_pop),
      .in_stalled());

   rdmx_header_gen header_gen (
      .payload_len(len_head), .target_addr(addr_head), .user_field(user_head),
      .seq_num(seq_num), .header_beat(header_beat));

   rdmx_tx_sequencer tx_seq (
      .dst_clk, .dst_resetn,
      .len_valid(len_valid), .addr_valid(addr_head_valid), .meta_pop(meta_pop),
      .len_head(len_head), .header_beat(header_beat),
      .data_head(data_head), .data_last(data_last), .data_valid(data_valid),
      .data_pop(data_pop), .seq_num(seq_num),
      .tx_data(tx_data), .tx_keep(tx_keep), .tx_last(tx_last), .tx_valid(tx_valid),
      .tx_ready(tx_ready));

endmodule

`default_nettype wire

// File: source/stream_fifo.sv
/* Single-clock FIFO with fall-through read from the head slot
   A write appears at the head one cycle later */
`timescale 1ns/1ps
`default_nettype none

`include "rdmx_defines.svh"

module stream_fifo #(
   parameter int WIDTH = `RDMX_DATA_W,
   parameter int DEPTH = `RDMX_META_DEPTH
) (
   input  wire              dst_clk,
   input  wire              dst_resetn,
   input  wire  [WIDTH-1:0] in_data,
   input  wire              in_valid,
   output logic             in_ready,
   output logic [WIDTH-1:0] out_data,
   output logic             out_valid,
   input  wire              out_ready,
   output logic             in_stalled
);

   localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CNT_W = $clog2(DEPTH + 1);

   logic [WIDTH-1:0] mem [DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [CNT_W-1:0] count;
   logic             push;
   logic             pop;

   // Occupancy drives both handshakes
   assign in_ready   = (count < CNT_W'(DEPTH));
   assign out_valid  = (count != '0);
   assign out_data   = mem[rd_ptr];
   assign push       = in_valid & in_ready;
   assign pop        = out_valid & out_ready;
   // Valid input turned away by a full buffer
   assign in_stalled = in_valid & ~in_ready;

   always_ff @(posedge dst_clk) begin
      if (!dst_resetn) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push) begin
            wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         end
         if (pop) begin
            rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         end
         case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   // Storage array
   always_ff @(posedge dst_clk) begin
      if (push) begin
         mem[wr_ptr] <= in_data;
      end
   end

   // Pointers meet only when the buffer is empty or full
   assert property (@(posedge dst_clk) disable iff (!dst_resetn)
      (wr_ptr == rd_ptr) == (count == '0 || count == CNT_W'(DEPTH)));

   // Refused head entry stays in place until popped
   assert property (@(posedge dst_clk) disable iff (!dst_resetn)
      out_valid && !out_ready |=> out_valid && $stable(out_data));

endmodule

`default_nettype wire

// File: verification/rdmx_xmit_tb.sv
/* Random frames against a header and frame model, fixed seed
   Packets of 1 to 256 bytes with a tx_ready pattern drawn up front from the same seed */
`timescale 1ns/1ps
`default_nettype none

`include "rdmx_defines.svh"

module rdmx_xmit_tb;

   logic         dst_clk = 1'b0;
   logic         dst_resetn;
   logic [15:0]  plen_data;
   logic         plen_valid;
   wire          plen_ready;
   logic [63:0]  addr_data;
   logic [39:0]  addr_user;
   logic         addr_valid;
   wire          addr_ready;
   logic [511:0] pkt_data;
   logic         pkt_last;
   logic         pkt_valid;
   wire          pkt_ready;
   wire  [511:0] tx_data;
   wire  [63:0]  tx_keep;
   wire          tx_last;
   wire          tx_valid;
   logic         tx_ready;
   wire          data_fifo_full;

   // Expected output beats, oldest first
   logic [511:0] exp_data[$];
   logic [63:0]  exp_keep[$];
   logic         exp_last[$];
   logic         exp_hdr[$];

   logic         ready_pat[4096];
   logic         random_ready = 1'b0;
   int           cyc = 0;
   logic         prev_stall = 1'b0;
   logic [511:0] prev_data;
   logic         prev_last;
   logic [15:0]  seq_model = 16'd1;
   logic         full_seen;
   int           frames_seen = 0;
   int           checks = 0;
   int           idle_err = 0;
   int           hdr_err = 0;
   int           pay_err = 0;
   int           keep_err = 0;
   int           flow_err = 0;
   int           full_err = 0;
   int           t;

   rdmx_xmit UUT (
      .dst_clk, .dst_resetn,
      .plen_data, .plen_valid, .plen_ready,
      .addr_data, .addr_user, .addr_valid, .addr_ready,
      .pkt_data, .pkt_last, .pkt_valid, .pkt_ready,
      .tx_data, .tx_keep, .tx_last, .tx_valid, .tx_ready,
      .data_fifo_full);

   always #4 dst_clk = ~dst_clk;

   // Back-pressure from the precomputed pattern
   always @(negedge dst_clk) begin
      tx_ready = random_ready && ready_pat[cyc % 4096];
      cyc++;
   end

   // ==============================
   // Reference model
   // ==============================
   // Field value goes MSB first, starting at byte lane off
   function automatic logic [511:0] place(input logic [511:0] beat, input int off,
                                          input int n, input logic [63:0] val);
      logic [511:0] b;
      b = beat;
      for (int k = 0; k < n; k++) begin
         b[(off + k)*8 +: 8] = val[(n - 1 - k)*8 +: 8];
      end
      return b;
   endfunction

   function automatic logic [511:0] model_header(input logic [15:0] len,
         input logic [63:0] addr, input logic [39:0] user, input logic [15:0] seq);
      logic [511:0] h;
      logic [31:0]  sum;
      h = '0;
      h = place(h, 0, 6, 48'hFFFF_FFFF_FFFF);
      h = place(h, 6, 6, `RDMX_SRC_MAC);
      h = place(h, 12, 2, 16'h0800);
      h = place(h, 14, 2, `RDMX_IP_VER_DSF);
      // IPv4 total length counts IP, UDP and RDMX headers
      h = place(h, 16, 2, len + 16'd50);
      h = place(h, 18, 2, `RDMX_IP_ID);
      h = place(h, 20, 2, `RDMX_IP_FLAGS);
      h = place(h, 22, 2, `RDMX_IP_TTL_PROT);
      h = place(h, 26, 4, `RDMX_SRC_IP);
      h = place(h, 30, 4, `RDMX_DST_IP);
      // Checksum lanes are still zero while summing
      sum = '0;
      for (int j = 14; j < 34; j += 2) begin
         sum += {h[j*8 +: 8], h[(j + 1)*8 +: 8]};
      end
      h = place(h, 24, 2, ~(sum[15:0] + sum[31:16]));
      h = place(h, 34, 2, `RDMX_SRC_PORT);
      h = place(h, 36, 2, `RDMX_DST_PORT);
      h = place(h, 38, 2, len + 16'd30);
      h = place(h, 42, 2, `RDMX_MAGIC);
      h = place(h, 44, 8, addr);
      h = place(h, 52, 2, seq);
      h = place(h, 54, 4, user[31:0]);
      h = place(h, 58, 1, user[39:32]);
      return h;
   endfunction

   task automatic abort_run(input string why);
      $display("%0t: %s", $time, why);
      $display("Testbench failed");
      $finish;
   endtask

   function automatic logic stream_ready(input int s);
      case (s)
         0:       return pkt_ready;
         1:       return addr_ready;
         default: return plen_ready;
      endcase
   endfunction

   // Ready only moves at the rising edge, so the falling edge sees it settled
   task automatic handshake(input int s, input string what);
      int n;
      n = 0;
      while (!stream_ready(s) && n < 200) begin
         @(negedge dst_clk);
         n++;
      end
      if (!stream_ready(s)) begin
         abort_run({what, " was never accepted"});
      end else begin
         @(posedge dst_clk);
         @(negedge dst_clk);
      end
   endtask

   task automatic send_beat(input logic [511:0] d, input logic l);
      pkt_data  = d;
      pkt_last  = l;
      pkt_valid = 1'b1;
      handshake(0, "data beat");
      pkt_valid = 1'b0;
   endtask

   task automatic send_packet(input int idx);
      logic [15:0]  len;
      logic [63:0]  addr;
      logic [39:0]  user;
      logic [511:0] beat;
      logic [63:0]  keep;
      int           nbeats;
      // Every fifth packet is whole beats so the last keep is full
      if (idx % 5 == 0) begin
         len = 16'(64 * (1 + (idx / 5) % 4));
      end else begin
         len = 16'(1 + $urandom % 256);
      end
      addr   = {$urandom, $urandom};
      user   = {8'($urandom), 32'($urandom)};
      nbeats = (len + 63) / 64;
      exp_data.push_back(model_header(len, addr, user, seq_model));
      exp_keep.push_back('1);
      exp_last.push_back(1'b0);
      exp_hdr.push_back(1'b1);
      seq_model++;
      for (int b = 0; b < nbeats; b++) begin
         for (int w = 0; w < 16; w++) begin
            beat[w*32 +: 32] = $urandom;
         end
         keep = '1;
         // Partial last beat keeps only its valid low lanes
         if (b == nbeats - 1 && len % 64 != 0) begin
            for (int k = 0; k < 64; k++) begin
               keep[k] = (k < len % 64);
            end
         end
         exp_data.push_back(beat);
         exp_keep.push_back(keep);
         exp_last.push_back(b == nbeats - 1);
         exp_hdr.push_back(1'b0);
         send_beat(beat, b == nbeats - 1);
      end
      addr_data  = addr;
      addr_user  = user;
      addr_valid = 1'b1;
      handshake(1, "address entry");
      addr_valid = 1'b0;
      plen_data  = len;
      plen_valid = 1'b1;
      handshake(2, "length entry");
      plen_valid = 1'b0;
   endtask

   // ==============================
   // Output monitor
   // ==============================
   task automatic check_beat();
      logic is_hdr;
      checks++;
      assert (exp_data.size() != 0) else begin
         $display("%0t: output beat arrived with no beat expected", $time);
         flow_err++;
      end
      if (exp_data.size() != 0) begin
         is_hdr = exp_hdr.pop_front();
         if (is_hdr) frames_seen++;
         checks += 3;
         assert (tx_data === exp_data[0]) else begin
            $display("FAIL %0t tx_data exp %h got %h", $time, exp_data[0], tx_data);
            if (is_hdr) hdr_err++;
            else pay_err++;
         end
         assert (tx_keep === exp_keep[0]) else begin
            $display("FAIL %0t tx_keep exp %h got %h", $time, exp_keep[0], tx_keep);
            keep_err++;
         end
         assert (tx_last === exp_last[0]) else begin
            $display("FAIL %0t tx_last exp %b got %b", $time, exp_last[0], tx_last);
            pay_err++;
         end
         void'(exp_data.pop_front());
         void'(exp_keep.pop_front());
         void'(exp_last.pop_front());
      end
   endtask

   always @(posedge dst_clk) begin
      if (dst_resetn) begin
         // A refused beat must come back unchanged
         if (prev_stall) begin
            checks++;
            assert (tx_valid === 1'b1 && tx_data === prev_data && tx_last === prev_last)
            else begin
               $display("FAIL %0t stalled tx_valid/tx_last/tx_data exp 1/%b/%h got %b/%b/%h",
                        $time, prev_last, prev_data, tx_valid, tx_last, tx_data);
               flow_err++;
            end
         end
         if (tx_valid && tx_ready) check_beat();
         prev_stall = tx_valid && !tx_ready;
         prev_data  = tx_data;
         prev_last  = tx_last;
      end
   end

   // ==============================
   // Test sequence
   // ==============================
   initial begin
      void'($urandom(19586));
      dst_resetn = 1'b0;
      plen_data  = '0;
      plen_valid = 1'b0;
      addr_data  = '0;
      addr_user  = '0;
      addr_valid = 1'b0;
      pkt_data   = '0;
      pkt_last   = 1'b0;
      pkt_valid  = 1'b0;
      tx_ready   = 1'b0;
      for (int i = 0; i < 4096; i++) begin
         ready_pat[i] = ($urandom % 4) != 0;
      end
      repeat (16) @(posedge dst_clk);
      @(negedge dst_clk);
      dst_resetn = 1'b1;

      // Idle outputs with nothing written
      repeat (20) begin
         @(posedge dst_clk);
         checks++;
         assert (tx_valid === 1'b0 && data_fifo_full === 1'b0) else begin
            $display("FAIL %0t tx_valid/data_fifo_full exp 0/0 got %b/%b",
                     $time, tx_valid, data_fifo_full);
            idle_err++;
         end
      end
      $display("Test 1 idle after reset: %0d errors", idle_err);

      @(negedge dst_clk);
      random_ready = 1'b1;
      for (int p = 0; p < 40; p++) begin
         send_packet(p);
      end
      t = 0;
      while (exp_data.size() != 0 && t < 20000) begin
         @(negedge dst_clk);
         t++;
      end
      if (exp_data.size() != 0) abort_run("frames did not drain from the output");
      checks++;
      assert (frames_seen == 40) else begin
         $display("FAIL %0t frames_seen exp 40 got %0d", $time, frames_seen);
         flow_err++;
      end
      $display("Test 2 header beats over %0d frames: %0d errors", frames_seen, hdr_err);
      $display("Test 3 payload beats and tx_last: %0d errors", pay_err);
      $display("Test 4 tx_keep: %0d errors", keep_err);
      $display("Test 5 random tx_ready over 40 packets: %0d errors", flow_err);

      // Fill the data FIFO with no length so no frame can start
      random_ready = 1'b0;
      @(negedge dst_clk);
      repeat (32) send_beat({16{$urandom}}, 1'b0);
      pkt_data  = '1;
      pkt_valid = 1'b1;
      full_seen = 1'b0;
      t = 0;
      while (!full_seen && t < 50) begin
         @(posedge dst_clk);
         if (data_fifo_full) full_seen = 1'b1;
         t++;
      end
      @(negedge dst_clk);
      pkt_valid = 1'b0;
      checks++;
      assert (full_seen) else begin
         $display("%0t: data_fifo_full never rose with a full FIFO", $time);
         full_err++;
      end
      $display("Test 6 data_fifo_full: %0d errors", full_err);

      $display("Summary: %0d checks, %0d errors", checks,
               idle_err + hdr_err + pay_err + keep_err + flow_err + full_err);
      if (idle_err + hdr_err + pay_err + keep_err + flow_err + full_err == 0) begin
         $display("Testbench passed");
      end else begin
         $display("Testbench failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+source
source/rdmx_pkg.sv
source/stream_fifo.sv
source/rdmx_header_gen.sv
source/rdmx_tx_sequencer.sv
source/rdmx_xmit.sv
verification/rdmx_xmit_tb.sv
